/* kd_ctrl.f */
source/kd_pkg.sv
source/kd_mode_ctrl.sv
source/kd_load_seq.sv
source/kd_result_sender.sv
source/kd_ctrl_top.sv
bench/kd_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the kd_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal -f kd_ctrl.f --top-module kd_ctrl_tb -o kd_ctrl_sim
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

out=$(./obj_dir/kd_ctrl_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Verification passed"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

/* bench/kd_ctrl_stimulus.txt */
// first value is the number of records, all values in hex
// record: cmd (0 load, 1 send, 2 load and send together), enq percent,
// wfull_n percent, stray command while busy (0 none, 1 load, 2 send), expected count
8
// full rate load, then an unstalled send
0 64 64 0 42d
1 64 64 0 5ca
// half rate load with a stray send
0 32 64 2 42d
// stalled send with a stray load
1 64 32 1 5ca
0 4b 4b 1 42d
// heavy back-pressure, stray send while sending
1 64 1e 2 5ca
// both commands in the same idle cycle, send wins
2 4b 5a 0 5ca
0 1e 64 0 42d

/* bench/kd_ctrl_tb.sv */
module kd_ctrl_tb;

    logic                          clk;
    logic                          rst_n;
    logic                          load_kdtree;
    logic                          send_best_arr;
    logic                          load_done;
    logic                          send_done;
    logic                          agg_receiver_enq;
    logic                          agg_receiver_full_n;
    logic                          agg_change_fetch_width;
    logic [kd_pkg::fetch_w-1:0]    agg_input_fetch_width;
    logic                          int_node_sender_enable;
    logic [kd_pkg::leaf_addrw-1:0] int_node_sender_addr;
    logic [kd_pkg::leaf_size-1:0]  leaf_mem_csb0;
    logic [kd_pkg::leaf_size-1:0]  leaf_mem_web0;
    logic [kd_pkg::leaf_addrw-1:0] leaf_mem_addr0;
    logic                          qp_mem_csb0;
    logic                          qp_mem_web0;
    logic [kd_pkg::qp_addrw-1:0]   qp_mem_addr0;
    logic                          best_arr_csb1;
    logic [kd_pkg::best_addrw-1:0] best_arr_addr1;
    logic                          out_fifo_wenq;
    kd_pkg::out_sel_e              out_fifo_wdata_sel;
    logic                          out_fifo_wfull_n;

    logic [15:0] stim_mem [0:63];
    integer      seed;

    kd_ctrl_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("** Error at time %0t: %s is %0d, expected %0d",
                     $time, name, actual, expected);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run aborted");
    endtask

    function automatic logic chance(input int pct);
        int roll;
        roll = $unsigned($random(seed)) % 100;
        return roll < pct;
    endfunction

    task automatic check_idle_outputs();
        check_value("leaf_mem_csb0", leaf_mem_csb0, (1 << kd_pkg::leaf_size) - 1);
        check_value("leaf_mem_web0", leaf_mem_web0, (1 << kd_pkg::leaf_size) - 1);
        check_value("qp_mem_csb0", qp_mem_csb0, 1);
        check_value("qp_mem_web0", qp_mem_web0, 1);
        check_value("best_arr_csb1", best_arr_csb1, 1);
        check_value("int_node_sender_enable", int_node_sender_enable, 0);
        check_value("agg_receiver_full_n", agg_receiver_full_n, 0);
        check_value("agg_change_fetch_width", agg_change_fetch_width, 0);
        check_value("out_fifo_wenq", out_fifo_wenq, 0);
        check_value("out_fifo_wdata_sel", int'(out_fifo_wdata_sel), 0);
        check_value("load_done", load_done, 0);
        check_value("send_done", send_done, 0);
    endtask

    // expected strobes for the load cycle that would accept word n
    task automatic check_load_strobes(input logic accept, input int n);
        int                           m;
        int                           code;
        logic [kd_pkg::leaf_size-1:0] bank;
        logic                         node_en;
        logic                         qp_n;
        logic                         fetch;
        logic                         done;
        bank    = '1;
        node_en = 1'b0;
        qp_n    = 1'b1;
        fetch   = 1'b0;
        done    = 1'b0;
        code    = 0;
        if (accept && n < kd_pkg::num_nodes) begin
            node_en = 1'b1;
            check_value("int_node_sender_addr", int_node_sender_addr, n);
            fetch = (n == kd_pkg::num_nodes - 1);
            code  = kd_pkg::fetch_leaves;
        end else if (accept
                     && n < kd_pkg::num_nodes + kd_pkg::num_leaves * kd_pkg::leaf_size) begin
            m = n - kd_pkg::num_nodes;
            bank[m % kd_pkg::leaf_size] = 1'b0;
            check_value("leaf_mem_addr0", leaf_mem_addr0, m / kd_pkg::leaf_size);
            fetch = (m == kd_pkg::num_leaves * kd_pkg::leaf_size - 1);
            code  = kd_pkg::fetch_querys;
        end else if (accept) begin
            m    = n - kd_pkg::num_nodes - kd_pkg::num_leaves * kd_pkg::leaf_size;
            qp_n = 1'b0;
            check_value("qp_mem_addr0", qp_mem_addr0, m);
            done = (m == kd_pkg::num_querys - 1);
        end
        check_value("int_node_sender_enable", int_node_sender_enable, node_en);
        check_value("leaf_mem_csb0", leaf_mem_csb0, bank);
        check_value("leaf_mem_web0", leaf_mem_web0, bank);
        check_value("qp_mem_csb0", qp_mem_csb0, qp_n);
        check_value("qp_mem_web0", qp_mem_web0, qp_n);
        check_value("agg_change_fetch_width", agg_change_fetch_width, fetch);
        if (fetch) begin
            check_value("agg_input_fetch_width", agg_input_fetch_width, code);
        end
        check_value("load_done", load_done, done);
    endtask

    task automatic run_load(input int enq_pct, input int full_pct, input int stray,
                            input int expected);
        int   n;
        int   cycles;
        logic finished;
        n        = 0;
        cycles   = 0;
        finished = 1'b0;
        @(posedge clk);
        load_kdtree <= 1'b1;
        @(negedge clk);
        check_value("agg_change_fetch_width", agg_change_fetch_width, 1);
        check_value("agg_input_fetch_width", agg_input_fetch_width, kd_pkg::fetch_nodes);
        check_value("agg_receiver_full_n", agg_receiver_full_n, 0);
        while (!finished) begin
            cycles++;
            if (cycles > 50000) begin
                abort_run("load did not finish within 50000 cycles");
            end
            @(posedge clk);
            load_kdtree      <= (cycles == 20 && stray == 1);
            send_best_arr    <= (cycles == 20 && stray == 2);
            agg_receiver_enq <= chance(enq_pct);
            out_fifo_wfull_n <= chance(full_pct);
            @(negedge clk);
            check_value("agg_receiver_full_n", agg_receiver_full_n, 1);
            check_value("best_arr_csb1", best_arr_csb1, 1);
            check_value("out_fifo_wenq", out_fifo_wenq, 0);
            check_load_strobes(agg_receiver_enq, n);
            if (agg_receiver_enq) begin
                n++;
            end
            finished = load_done;
        end
        check_value("accepted load words", n, expected);
    endtask

    task automatic run_send(input int cmd, input int enq_pct, input int full_pct,
                            input int stray, input int expected);
        int                            w;
        int                            k;
        int                            total;
        int                            cycles;
        int                            exp_sel;
        int                            exp_addr;
        logic                          exp_read;
        logic                          rd_prev;
        logic [kd_pkg::best_addrw-1:0] addr_prev;
        logic                          finished;
        total    = 2 * kd_pkg::half_querys + 2 * kd_pkg::num_querys;
        w        = 0;
        cycles   = 0;
        rd_prev  = 1'b0;
        finished = 1'b0;
        @(posedge clk);
        send_best_arr    <= 1'b1;
        load_kdtree      <= (cmd == 2);
        out_fifo_wfull_n <= chance(full_pct);
        @(negedge clk);
        // the sender is still idle in the start cycle
        check_value("best_arr_csb1", best_arr_csb1, 1);
        check_value("agg_change_fetch_width", agg_change_fetch_width, 0);
        while (!finished) begin
            cycles++;
            if (cycles > 50000) begin
                abort_run("send did not finish within 50000 cycles");
            end
            @(posedge clk);
            load_kdtree      <= (cycles == 20 && stray == 1);
            send_best_arr    <= (cycles == 20 && stray == 2);
            agg_receiver_enq <= chance(enq_pct);
            out_fifo_wfull_n <= chance(full_pct);
            @(negedge clk);
            check_value("agg_receiver_full_n", agg_receiver_full_n, 0);
            check_value("int_node_sender_enable", int_node_sender_enable, 0);
            if (!best_arr_csb1) begin
                check_value("out_fifo_wfull_n at read", out_fifo_wfull_n, 1);
                check_value("out_fifo_wenq at read", out_fifo_wenq, 0);
            end
            if (rd_prev) begin
                check_value("out_fifo_wenq after read", out_fifo_wenq, 1);
            end
            if (out_fifo_wenq) begin
                if (w < 2 * kd_pkg::half_querys) begin
                    exp_sel  = (w < kd_pkg::half_querys) ? int'(kd_pkg::sel_idx0)
                                                         : int'(kd_pkg::sel_idx1);
                    exp_addr = w % kd_pkg::half_querys;
                    exp_read = 1'b1;
                end else begin
                    k        = (w - 2 * kd_pkg::half_querys) % kd_pkg::num_querys;
                    exp_read = (k % 2 == 0);
                    exp_addr = k / 2;
                    if (!exp_read) begin
                        exp_sel = int'(kd_pkg::sel_dist_hi);
                    end else if (w < 2 * kd_pkg::half_querys + kd_pkg::num_querys) begin
                        exp_sel = int'(kd_pkg::sel_dist0);
                    end else begin
                        exp_sel = int'(kd_pkg::sel_dist1);
                    end
                end
                check_value("out_fifo_wdata_sel", int'(out_fifo_wdata_sel), exp_sel);
                check_value("read before write", rd_prev, exp_read);
                if (exp_read) begin
                    check_value("best_arr_addr1", addr_prev, exp_addr);
                end
                check_value("send_done", send_done, w == total - 1);
                w++;
            end else begin
                check_value("send_done", send_done, 0);
            end
            rd_prev   = !best_arr_csb1;
            addr_prev = best_arr_addr1;
            finished  = send_done;
        end
        check_value("FIFO writes", w, expected);
    endtask

    initial begin
        int num_records;
        int r;
        int base;
        seed             = 96309;
        rst_n            = 1'b0;
        load_kdtree      = 1'b0;
        send_best_arr    = 1'b0;
        agg_receiver_enq = 1'b0;
        out_fifo_wfull_n = 1'b0;
        $readmemh("bench/kd_ctrl_stimulus.txt", stim_mem);
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_idle_outputs();
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle_outputs();
        if ($isunknown(stim_mem[0]) || stim_mem[0] == 0) begin
            abort_run("no records found in bench/kd_ctrl_stimulus.txt");
        end
        num_records = stim_mem[0];
        for (r = 0; r < num_records; r++) begin
            base = 1 + r * 5;
            if (stim_mem[base] == 0) begin
                run_load(stim_mem[base+1], stim_mem[base+2], stim_mem[base+3],
                         stim_mem[base+4]);
            end else begin
                run_send(stim_mem[base], stim_mem[base+1], stim_mem[base+2],
                         stim_mem[base+3], stim_mem[base+4]);
            end
        end
        $display("Verification passed");
        $finish;
    end

endmodule

/* source/kd_ctrl_top.sv */
module kd_ctrl_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load_kdtree,
    input  logic                          send_best_arr,
    output logic                          load_done,
    output logic                          send_done,
    input  logic                          agg_receiver_enq,
    output logic                          agg_receiver_full_n,
    output logic                          agg_change_fetch_width,
    output logic [kd_pkg::fetch_w-1:0]    agg_input_fetch_width,
    output logic                          int_node_sender_enable,
    output logic [kd_pkg::leaf_addrw-1:0] int_node_sender_addr,
    output logic [kd_pkg::leaf_size-1:0]  leaf_mem_csb0,
    output logic [kd_pkg::leaf_size-1:0]  leaf_mem_web0,
    output logic [kd_pkg::leaf_addrw-1:0] leaf_mem_addr0,
    output logic                          qp_mem_csb0,
    output logic                          qp_mem_web0,
    output logic [kd_pkg::qp_addrw-1:0]   qp_mem_addr0,
    output logic                          best_arr_csb1,
    output logic [kd_pkg::best_addrw-1:0] best_arr_addr1,
    output logic                          out_fifo_wenq,
    output kd_pkg::out_sel_e              out_fifo_wdata_sel,
    input  logic                          out_fifo_wfull_n
);

    logic load_start;
    logic send_start;

    kd_mode_ctrl mode_ctrl0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_kdtree   (load_kdtree),
        .send_best_arr (send_best_arr),
        .load_done     (load_done),
        .send_done     (send_done),
        .load_start    (load_start),
        .send_start    (send_start)
    );

    kd_load_seq load_seq0 (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .load_start             (load_start),
        .agg_receiver_enq       (agg_receiver_enq),
        .load_done              (load_done),
        .agg_receiver_full_n    (agg_receiver_full_n),
        .agg_change_fetch_width (agg_change_fetch_width),
        .agg_input_fetch_width  (agg_input_fetch_width),
        .int_node_sender_enable (int_node_sender_enable),
        .int_node_sender_addr   (int_node_sender_addr),
        .leaf_mem_csb0          (leaf_mem_csb0),
        .leaf_mem_web0          (leaf_mem_web0),
        .leaf_mem_addr0         (leaf_mem_addr0),
        .qp_mem_csb0            (qp_mem_csb0),
        .qp_mem_web0            (qp_mem_web0),
        .qp_mem_addr0           (qp_mem_addr0)
    );

    kd_result_sender result_sender0 (
        .clk                (clk),
        .rst_n              (rst_n),
        .send_start         (send_start),
        .out_fifo_wfull_n   (out_fifo_wfull_n),
        .send_done          (send_done),
        .best_arr_csb1      (best_arr_csb1),
        .best_arr_addr1     (best_arr_addr1),
        .out_fifo_wenq      (out_fifo_wenq),
        .out_fifo_wdata_sel (out_fifo_wdata_sel)
    );

endmodule

/* source/kd_result_sender.sv */
module kd_result_sender (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          send_start,
    input  logic                          out_fifo_wfull_n,
    output logic                          send_done,
    output logic                          best_arr_csb1,
    output logic [kd_pkg::best_addrw-1:0] best_arr_addr1,
    output logic                          out_fifo_wenq,
    output kd_pkg::out_sel_e              out_fifo_wdata_sel
);

    kd_pkg::send_state_e state_q;
    kd_pkg::send_state_e state_d;
    kd_pkg::send_state_e pass_next;
    kd_pkg::out_sel_e    sel_rd;
    kd_pkg::out_sel_e    sel_d;

    logic [kd_pkg::cnt_w-1:0] cnt;
    logic [kd_pkg::cnt_w-1:0] cnt_last;
    logic                     cnt_done;
    logic                     dist_pass;
    logic                     rd_ok;
    logic                     send_hi;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= kd_pkg::sd_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // counts FIFO writes within a pass
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (out_fifo_wenq && state_q != kd_pkg::sd_idle) begin
            if (cnt_done) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign cnt_done = (cnt == cnt_last);

    // wfull_n lags a write by one cycle, so wait out the cycle after each wenq
    assign rd_ok = !out_fifo_wenq && out_fifo_wfull_n;

    // per-pass settings
    always_comb begin
        pass_next = kd_pkg::sd_idle;
        sel_rd    = kd_pkg::sel_idx0;
        dist_pass = 1'b0;
        cnt_last  = kd_pkg::cnt_w'(kd_pkg::half_querys - 1);
        case (state_q)
            kd_pkg::sd_idx0: begin
                pass_next = kd_pkg::sd_idx1;
            end
            kd_pkg::sd_idx1: begin
                pass_next = kd_pkg::sd_dist0;
                sel_rd    = kd_pkg::sel_idx1;
            end
            kd_pkg::sd_dist0: begin
                pass_next = kd_pkg::sd_dist1;
                sel_rd    = kd_pkg::sel_dist0;
                dist_pass = 1'b1;
                cnt_last  = kd_pkg::cnt_w'(kd_pkg::num_querys - 1);
            end
            kd_pkg::sd_dist1: begin
                sel_rd    = kd_pkg::sel_dist1;
                dist_pass = 1'b1;
                cnt_last  = kd_pkg::cnt_w'(kd_pkg::num_querys - 1);
            end
            default: begin
                pass_next = kd_pkg::sd_idle;
            end
        endcase
    end

    always_comb begin
        state_d        = state_q;
        send_done      = 1'b0;
        best_arr_csb1  = 1'b1;
        best_arr_addr1 = '0;
        send_hi        = 1'b0;
        sel_d          = sel_rd;

        if (state_q == kd_pkg::sd_idle) begin
            if (send_start) begin
                state_d = kd_pkg::sd_idx0;
            end
        end else begin
            if (rd_ok) begin
                // a distance is 22 bits wide, odd counts carry its upper half
                if (dist_pass && cnt[0]) begin
                    send_hi = 1'b1;
                    sel_d   = kd_pkg::sel_dist_hi;
                end else begin
                    best_arr_csb1 = 1'b0;
                    if (dist_pass) begin
                        best_arr_addr1 = cnt[kd_pkg::best_addrw:1];
                    end else begin
                        best_arr_addr1 = cnt[kd_pkg::best_addrw-1:0];
                    end
                end
            end
            if (out_fifo_wenq && cnt_done) begin
                state_d   = pass_next;
                send_done = (state_q == kd_pkg::sd_dist1);
            end
        end
    end

    // best array read data arrives one cycle later together with the write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_fifo_wenq      <= 1'b0;
            out_fifo_wdata_sel <= kd_pkg::sel_idx0;
        end else begin
            out_fifo_wenq      <= !best_arr_csb1 || send_hi;
            out_fifo_wdata_sel <= sel_d;
        end
    end

    a_no_read_during_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_fifo_wenq |-> best_arr_csb1
    );

endmodule

/* source/kd_load_seq.sv */
module kd_load_seq (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          load_start,
    input  logic                          agg_receiver_enq,
    output logic                          load_done,
    output logic                          agg_receiver_full_n,
    output logic                          agg_change_fetch_width,
    output logic [kd_pkg::fetch_w-1:0]    agg_input_fetch_width,
    output logic                          int_node_sender_enable,
    output logic [kd_pkg::leaf_addrw-1:0] int_node_sender_addr,
    output logic [kd_pkg::leaf_size-1:0]  leaf_mem_csb0,
    output logic [kd_pkg::leaf_size-1:0]  leaf_mem_web0,
    output logic [kd_pkg::leaf_addrw-1:0] leaf_mem_addr0,
    output logic                          qp_mem_csb0,
    output logic                          qp_mem_web0,
    output logic [kd_pkg::qp_addrw-1:0]   qp_mem_addr0
);

    kd_pkg::load_state_e state_q;
    kd_pkg::load_state_e state_d;

    logic [kd_pkg::cnt_w-1:0]     cnt;
    logic [kd_pkg::cnt_w-1:0]     cnt_last;
    logic                         cnt_en;
    logic                         cnt_done;
    logic [kd_pkg::leaf_size-1:0] bank_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= kd_pkg::ld_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // one counter shared by all three sections, wraps at the section end
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (cnt_en) begin
            if (cnt_done) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    assign cnt_done = (cnt == cnt_last);

    // low counter bits pick one active-low leaf bank
    always_comb begin
        bank_sel = '1;
        bank_sel[cnt[$clog2(kd_pkg::leaf_size)-1:0]] = 1'b0;
    end

    always_comb begin
        state_d                = state_q;
        cnt_en                 = 1'b0;
        cnt_last               = '0;
        load_done              = 1'b0;
        agg_receiver_full_n    = 1'b0;
        agg_change_fetch_width = 1'b0;
        agg_input_fetch_width  = '0;
        int_node_sender_enable = 1'b0;
        int_node_sender_addr   = '0;
        leaf_mem_csb0          = '1;
        leaf_mem_web0          = '1;
        leaf_mem_addr0         = '0;
        qp_mem_csb0            = 1'b1;
        qp_mem_web0            = 1'b1;
        qp_mem_addr0           = '0;

        case (state_q)
            kd_pkg::ld_idle: begin
                if (load_start) begin
                    state_d                = kd_pkg::ld_nodes;
                    agg_change_fetch_width = 1'b1;
                    agg_input_fetch_width  = kd_pkg::fetch_nodes;
                end
            end

            kd_pkg::ld_nodes: begin
                cnt_last             = kd_pkg::cnt_w'(kd_pkg::num_nodes - 1);
                agg_receiver_full_n  = 1'b1;
                int_node_sender_addr = cnt[kd_pkg::leaf_addrw-1:0];
                if (agg_receiver_enq) begin
                    int_node_sender_enable = 1'b1;
                    cnt_en                 = 1'b1;
                    if (cnt_done) begin
                        state_d                = kd_pkg::ld_leaves;
                        agg_change_fetch_width = 1'b1;
                        agg_input_fetch_width  = kd_pkg::fetch_leaves;
                    end
                end
            end

            kd_pkg::ld_leaves: begin
                cnt_last            = kd_pkg::cnt_w'(kd_pkg::num_leaves * kd_pkg::leaf_size - 1);
                agg_receiver_full_n = 1'b1;
                if (agg_receiver_enq) begin
                    cnt_en         = 1'b1;
                    leaf_mem_csb0  = bank_sel;
                    leaf_mem_web0  = bank_sel;
                    leaf_mem_addr0 = cnt[$clog2(kd_pkg::leaf_size) +: kd_pkg::leaf_addrw];
                    if (cnt_done) begin
                        state_d                = kd_pkg::ld_querys;
                        agg_change_fetch_width = 1'b1;
                        agg_input_fetch_width  = kd_pkg::fetch_querys;
                    end
                end
            end

            kd_pkg::ld_querys: begin
                cnt_last            = kd_pkg::cnt_w'(kd_pkg::num_querys - 1);
                agg_receiver_full_n = 1'b1;
                if (agg_receiver_enq) begin
                    cnt_en       = 1'b1;
                    qp_mem_csb0  = 1'b0;
                    qp_mem_web0  = 1'b0;
                    qp_mem_addr0 = cnt[kd_pkg::qp_addrw-1:0];
                    if (cnt_done) begin
                        state_d   = kd_pkg::ld_idle;
                        load_done = 1'b1;
                    end
                end
            end

            default: begin
                state_d = kd_pkg::ld_idle;
            end
        endcase
    end

    // nothing may be written unless the aggregator was offered a slot
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (!rst_n)
        !agg_receiver_full_n |->
            (&leaf_mem_csb0) && (&leaf_mem_web0) && qp_mem_csb0 && qp_mem_web0
            && !int_node_sender_enable
    );

endmodule

/* source/kd_mode_ctrl.sv */
module kd_mode_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic load_kdtree,
    input  logic send_best_arr,
    input  logic load_done,
    input  logic send_done,
    output logic load_start,
    output logic send_start
);

    kd_pkg::mode_e mode_q;
    kd_pkg::mode_e mode_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_q <= kd_pkg::mode_idle;
        end else begin
            mode_q <= mode_d;
        end
    end

    // commands are only taken in idle, anything arriving while busy is dropped
    always_comb begin
        mode_d     = mode_q;
        load_start = 1'b0;
        send_start = 1'b0;

        case (mode_q)
            kd_pkg::mode_idle: begin
                // send wins when both commands land together
                if (send_best_arr) begin
                    mode_d     = kd_pkg::mode_send;
                    send_start = 1'b1;
                end else if (load_kdtree) begin
                    mode_d     = kd_pkg::mode_load;
                    load_start = 1'b1;
                end
            end

            kd_pkg::mode_load: begin
                if (load_done) begin
                    mode_d = kd_pkg::mode_idle;
                end
            end

            kd_pkg::mode_send: begin
                if (send_done) begin
                    mode_d = kd_pkg::mode_idle;
                end
            end

            default: begin
                mode_d = kd_pkg::mode_idle;
            end
        endcase
    end

    // done pulses from the sequencers must match the running mode
    a_load_done_in_load: assert property (
        @(posedge clk) disable iff (!rst_n)
        load_done |-> mode_q == kd_pkg::mode_load
    );

    a_send_done_in_send: assert property (
        @(posedge clk) disable iff (!rst_n)
        send_done |-> mode_q == kd_pkg::mode_send
    );

endmodule

/* source/kd_pkg.sv */
package kd_pkg;

    // tree and query grid sizes, fixed by the memories
    localparam int num_leaves  = 64;
    localparam int leaf_size   = 8;
    localparam int num_nodes   = num_leaves - 1;
    localparam int row_size    = 26;
    localparam int col_size    = 19;
    localparam int num_querys  = row_size * col_size;
    localparam int half_querys = num_querys / 2;

    localparam int leaf_addrw = $clog2(num_leaves);
    localparam int qp_addrw   = $clog2(num_querys);
    localparam int best_addrw = $clog2(half_querys);
    // must hold the longest section, the 512 leaf words
    localparam int cnt_w      = $clog2(num_leaves * leaf_size + 1);

    // fetch-width codes for the input aggregator
    localparam int fetch_w = 3;
    localparam logic [fetch_w-1:0] fetch_nodes  = 3'd1;
    localparam logic [fetch_w-1:0] fetch_leaves = 3'd5;
    localparam logic [fetch_w-1:0] fetch_querys = 3'd4;

    typedef enum logic [1:0] {
        mode_idle,
        mode_load,
        mode_send
    } mode_e;

    typedef enum logic [1:0] {
        ld_idle,
        ld_nodes,
        ld_leaves,
        ld_querys
    } load_state_e;

    typedef enum logic [2:0] {
        sd_idle,
        sd_idx0,
        sd_idx1,
        sd_dist0,
        sd_dist1
    } send_state_e;

    // output FIFO data mux select
    typedef enum logic [2:0] {
        sel_idx0    = 3'd0,
        sel_idx1    = 3'd1,
        sel_dist0   = 3'd2,
        sel_dist1   = 3'd3,
        sel_dist_hi = 3'd4
    } out_sel_e;

endpackage
